// ==== aluCluster.f ====
logic/aluClusterPkg.sv
logic/barrelShifter.sv
logic/cla16.sv
logic/aluLane.sv
logic/issueDecoder.sv
logic/flagCollector.sv
logic/aluCluster.sv
dv/aluCluster_asserts.sv
dv/aluClusterTb.sv

// ==== dv/aluClusterTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluClusterTb;

	localparam int LANES = 4;

	typedef aluClusterPkg::operandPair [LANES-1:0] opArray;

	typedef struct packed {
		logic [LANES-1:0][15:0] results;
		logic [LANES-1:0]       zeroMask;
		logic [LANES-1:0]       oflMask;
		logic                   illegal;
	} expectRec;

	typedef struct packed {
		logic [15:0] word;
		opArray      ops;
		logic [1:0]  gap;
		expectRec    exp;
	} stimEntry;

	logic                    clk = 1'b0;
	logic                    reset;
	logic                    inValid;
	aluClusterPkg::instrWord instr;
	opArray                  operands;
	logic                    outValid;
	logic [LANES-1:0][15:0]  results;
	logic [LANES-1:0]        zeroMask;
	logic [LANES-1:0]        oflMask;
	logic                    allZero;
	logic                    anyOfl;
	logic                    illegal;

	stimEntry stimTable[$];
	int       dueQ[$];
	expectRec expQ[$];
	int       cycles = 0;
	int       limit = 0;
	int       seed = 32'h8fd5_b002;

	aluCluster #(.NUM_LANES(LANES)) u_aluCluster (
		.clk      (clk),
		.reset    (reset),
		.inValid  (inValid),
		.instr    (instr),
		.operands (operands),
		.outValid (outValid),
		.results  (results),
		.zeroMask (zeroMask),
		.oflMask  (oflMask),
		.allZero  (allZero),
		.anyOfl   (anyOfl),
		.illegal  (illegal)
	);

	always #4 clk = ~clk;

	task automatic stopRun(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] want);
		if (got !== want) begin
			stopRun($sformatf("error %s: got 0x%0h expected 0x%0h", name, got, want));
		end
	endtask

	function automatic bit ovf16(input int v);
		return (v > 32767) || (v < -32768);
	endfunction

	// one lane as the op table describes it
	function automatic aluClusterPkg::laneResult laneModel(input logic [3:0] op, input logic sgn,
			input logic [15:0] a, input logic [15:0] b);
		aluClusterPkg::laneResult r;
		logic [16:0] wide;
		logic [31:0] dbl;
		int          sa;
		int          sb;
		wide = {1'b0, a} + {1'b0, b};
		sa = int'($signed(a));
		sb = int'($signed(b));
		r.value = '0;
		r.ofl = 1'b0;
		// adder sees plain A+B unless the op inverts an input
		r.zero = (wide[15:0] == 16'h0);
		case (op)
			aluClusterPkg::ADD: begin
				r.value = wide[15:0];
				r.ofl = sgn ? ovf16(sa + sb) : wide[16];
			end
			aluClusterPkg::SUB: begin
				r.value = b - a;
				r.zero = (a == b);
				r.ofl = sgn ? ovf16(sb - sa) : (b >= a);
			end
			aluClusterPkg::ROL: begin
				dbl = {a, a} << b[3:0];
				r.value = dbl[31:16];
			end
			aluClusterPkg::ROR: begin
				dbl = {a, a} >> b[3:0];
				r.value = dbl[15:0];
			end
			aluClusterPkg::SLL: r.value = a << b[3:0];
			aluClusterPkg::SRL: r.value = a >> b[3:0];
			aluClusterPkg::BTR: begin
				for (int i = 0; i < 16; i++) begin
					r.value[i] = a[15-i];
				end
			end
			aluClusterPkg::XOR: r.value = a ^ b;
			aluClusterPkg::SEQ: begin
				r.value = {15'b0, a == b};
				r.zero = (a == b);
			end
			aluClusterPkg::SLT, aluClusterPkg::SLE: begin
				r.zero = (a == b);
				r.ofl = sgn ? ovf16(sa - sb) : (a >= b);
				if (op == aluClusterPkg::SLT) begin
					r.value = {15'b0, sgn ? (sa < sb) : (a < b)};
				end else begin
					r.value = {15'b0, sgn ? (sa <= sb) : (a <= b)};
				end
			end
			aluClusterPkg::SCO: r.value = {15'b0, wide[16]};
			aluClusterPkg::SLBI: r.value = {a[7:0], b[7:0]};
			aluClusterPkg::ANDN: r.value = a & ~b;
			aluClusterPkg::LBI: r.value = b;
			default: r.value = '0;
		endcase
		return r;
	endfunction

	// bit 15 picks the format, I-form is signed with a sign-extended imm as B
	function automatic expectRec entryModel(input logic [15:0] word, input opArray ops);
		expectRec                 e;
		aluClusterPkg::laneResult r;
		logic [15:0]              b;
		logic                     sgn;
		sgn = word[15] ? 1'b1 : word[10];
		e.illegal = (word[14:11] == 4'hf);
		for (int i = 0; i < LANES; i++) begin
			b = word[15] ? {{5{word[10]}}, word[10:0]} : ops[i].inB;
			if (e.illegal) begin
				// load of a cleared B, adder still sees A
				r.value = '0;
				r.zero = (ops[i].inA == 16'h0);
				r.ofl = 1'b0;
			end else begin
				r = laneModel(word[14:11], sgn, ops[i].inA, b);
			end
			e.results[i] = r.value;
			e.zeroMask[i] = r.zero;
			e.oflMask[i] = r.ofl;
		end
		return e;
	endfunction

	function automatic logic [15:0] rWord(input logic [3:0] op, input logic sgn);
		return {1'b0, op, sgn, 10'h0};
	endfunction

	function automatic logic [15:0] iWord(input logic [3:0] op, input logic [10:0] imm);
		return {1'b1, op, imm};
	endfunction

	function automatic opArray spread(input logic [15:0] a0, input logic [15:0] b0,
			input logic [15:0] stepA, input logic [15:0] stepB);
		opArray ops;
		for (int i = 0; i < LANES; i++) begin
			ops[i].inA = a0 + 16'(i) * stepA;
			ops[i].inB = b0 + 16'(i) * stepB;
		end
		return ops;
	endfunction

	function automatic opArray randomOps();
		opArray ops;
		for (int i = 0; i < LANES; i++) begin
			ops[i].inA = 16'($random(seed));
			ops[i].inB = 16'($random(seed));
		end
		return ops;
	endfunction

	task automatic addEntry(input logic [15:0] word, input opArray ops, input logic [1:0] gap);
		stimEntry s;
		s.word = word;
		s.ops = ops;
		s.gap = gap;
		s.exp = entryModel(word, ops);
		stimTable.push_back(s);
	endtask

	task automatic buildTable();
		logic [15:0] word;
		logic [3:0]  op;
		// 7fff+1 and ffff+1 alternate across the lanes
		addEntry(rWord(aluClusterPkg::ADD, 1'b1), spread(16'h7fff, 16'h1, 16'h8000, 16'h0), 2'd0);
		addEntry(rWord(aluClusterPkg::ADD, 1'b0), spread(16'h7fff, 16'h1, 16'h8000, 16'h0), 2'd0);
		// sums cancel on every lane
		addEntry(rWord(aluClusterPkg::ADD, 1'b0), spread(16'h1234, 16'hedcc, 16'h1, 16'hffff), 2'd0);
		addEntry(rWord(aluClusterPkg::SUB, 1'b1), spread(16'h1, 16'h8000, 16'h0, 16'h8000), 2'd0);
		addEntry(rWord(aluClusterPkg::SUB, 1'b0), spread(16'h1, 16'h8000, 16'h0, 16'h8000), 2'd0);
		addEntry(rWord(aluClusterPkg::SUB, 1'b1), randomOps(), 2'd0);
		// ROL through BTR, counts 0-15 spread over the lanes
		for (int o = 2; o <= 6; o++) begin
			for (int c = 0; c < 16; c += 4) begin
				addEntry(rWord(4'(o), 1'b0),
					spread(16'h8d31 ^ 16'(c * 37), 16'(c), 16'h1111, 16'h1), 2'd0);
			end
		end
		addEntry(rWord(aluClusterPkg::XOR, 1'b0), randomOps(), 2'd0);
		addEntry(rWord(aluClusterPkg::ANDN, 1'b0), randomOps(), 2'd0);
		// same operands signed and unsigned, lane 2 holds an equal pair
		for (int o = 8; o <= 11; o++) begin
			for (int s = 0; s < 2; s++) begin
				addEntry(rWord(4'(o), 1'(s)),
					spread(16'h7fff, 16'hffff, 16'h8000, 16'h4000), 2'd0);
			end
		end
		addEntry(rWord(aluClusterPkg::SLE, 1'b1), randomOps(), 2'd0);
		addEntry(iWord(aluClusterPkg::LBI, 11'h7f0), randomOps(), 2'd3);
		addEntry(iWord(aluClusterPkg::LBI, 11'h155), randomOps(), 2'd0);
		addEntry(iWord(aluClusterPkg::SLBI, 11'h4a5), randomOps(), 2'd0);
		addEntry(iWord(aluClusterPkg::ADD, 11'h3ff), randomOps(), 2'd2);
		addEntry(rWord(4'hf, 1'b0), spread(16'h0, 16'hbeef, 16'h5a5a, 16'h1), 2'd1);
		addEntry(iWord(4'hf, 11'h123), randomOps(), 2'd0);
		for (int k = 0; k < 16; k++) begin
			op = 4'($unsigned($random(seed)) % 15);
			if ($random(seed) & 1) begin
				word = iWord(op, 11'($random(seed)));
			end else begin
				word = rWord(op, 1'($random(seed)));
			end
			addEntry(word, randomOps(), 2'($unsigned($random(seed)) % 2));
		end
	endtask

	task automatic checkOutputs(input expectRec e);
		checkValue("results", 64'(results), 64'(e.results));
		checkValue("zeroMask", 64'(zeroMask), 64'(e.zeroMask));
		checkValue("oflMask", 64'(oflMask), 64'(e.oflMask));
		checkValue("allZero", 64'(allZero), 64'(&e.zeroMask));
		checkValue("anyOfl", 64'(anyOfl), 64'(|e.oflMask));
		checkValue("illegal", 64'(illegal), 64'(e.illegal));
	endtask

	always @(posedge clk) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			stopRun($sformatf("timeout after %0d cycles with results still pending", cycles));
		end
	end

	// outputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin
		if (!reset) begin
			if (outValid === 1'b1) begin
				if (dueQ.size() == 0) begin
					stopRun("outValid went high with no instruction in flight");
				end else if (dueQ[0] != cycles) begin
					stopRun($sformatf("outValid came at cycle %0d instead of cycle %0d",
						cycles, dueQ[0]));
				end else begin
					checkOutputs(expQ.pop_front());
					void'(dueQ.pop_front());
				end
			end else if (dueQ.size() != 0 && dueQ[0] <= cycles) begin
				stopRun("outValid missing for an issued instruction");
			end else begin
				checkValue("illegal", 64'(illegal), 64'd0);
			end
		end
	end

	initial begin
		reset = 1'b1;
		inValid = 1'b0;
		instr = '0;
		operands = '0;
		buildTable();
		limit = stimTable.size() * 4 + 50;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checkValue("outValid", 64'(outValid), 64'd0);
		checkValue("illegal", 64'(illegal), 64'd0);
		foreach (stimTable[n]) begin
			repeat (stimTable[n].gap) begin
				inValid = 1'b0;
				@(negedge clk);
			end
			instr = stimTable[n].word;
			operands = stimTable[n].ops;
			inValid = 1'b1;
			// decoder edge, then lane edge
			dueQ.push_back(cycles + 2);
			expQ.push_back(stimTable[n].exp);
			@(negedge clk);
		end
		inValid = 1'b0;
		while (dueQ.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
		if (outValid !== 1'b0) begin
			stopRun("outValid stayed high after the last result");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== dv/aluCluster_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluCluster_asserts #(
	parameter int NUM_LANES = 4
) (
	input logic                                               clk,
	input logic                                               reset,
	input logic                                               inValid,
	input logic                                               outValid,
	input logic                                               illegal,
	input logic                                               allZero,
	input logic [NUM_LANES-1:0]                               zeroMask,
	input logic [NUM_LANES-1:0][aluClusterPkg::DATA_WIDTH-1:0] results
);

	// decoder stage plus lane stage
	validLatency: assert property (@(posedge clk) disable iff (reset)
		outValid == $past(inValid, 2))
		else $error("outValid does not follow inValid by two cycles");

	// an illegal word loads a cleared B on every lane
	illegalWithValid: assert property (@(posedge clk) disable iff (reset)
		illegal |-> outValid && (results == '0))
		else $error("illegal raised without outValid or with nonzero results");

	allZeroMatch: assert property (@(posedge clk) disable iff (reset)
		outValid |-> (allZero == &zeroMask))
		else $error("allZero differs from the AND of zeroMask");

endmodule

bind aluCluster aluCluster_asserts #(.NUM_LANES(NUM_LANES)) u_aluClusterAsserts (
	.clk      (clk),
	.reset    (reset),
	.inValid  (inValid),
	.outValid (outValid),
	.illegal  (illegal),
	.allZero  (allZero),
	.zeroMask (zeroMask),
	.results  (results)
);

`default_nettype wire

// ==== logic/aluCluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluCluster #(
	parameter int NUM_LANES = 4
) (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic                                               inValid,
	input  aluClusterPkg::instrWord                            instr,
	input  aluClusterPkg::operandPair [NUM_LANES-1:0]          operands,
	output logic                                               outValid,
	output logic [NUM_LANES-1:0][aluClusterPkg::DATA_WIDTH-1:0] results,
	output logic [NUM_LANES-1:0]                               zeroMask,
	output logic [NUM_LANES-1:0]                               oflMask,
	output logic                                               allZero,
	output logic                                               anyOfl,
	output logic                                               illegal
);

	logic                                      issueValid;
	logic                                      issueIllegal;
	aluClusterPkg::aluCtrl                     ctrl;
	aluClusterPkg::operandPair [NUM_LANES-1:0] laneOperands;
	logic [NUM_LANES-1:0]                      laneValid;
	aluClusterPkg::laneResult [NUM_LANES-1:0]  laneResults;

	issueDecoder #(.NUM_LANES(NUM_LANES)) u_issueDecoder (
		.clk          (clk),
		.reset        (reset),
		.inValid      (inValid),
		.instr        (instr),
		.operands     (operands),
		.issueValid   (issueValid),
		.ctrl         (ctrl),
		.laneOperands (laneOperands),
		.issueIllegal (issueIllegal)
	);

	// every lane sees the same controls
	generate
		for (genvar lane = 0; lane < NUM_LANES; lane++) begin : gLane
			aluLane u_aluLane (
				.clk        (clk),
				.reset      (reset),
				.issueValid (issueValid),
				.ctrl       (ctrl),
				.pair       (laneOperands[lane]),
				.laneValid  (laneValid[lane]),
				.result     (laneResults[lane])
			);
		end
	endgenerate

	flagCollector #(.NUM_LANES(NUM_LANES)) u_flagCollector (
		.clk          (clk),
		.reset        (reset),
		.laneValid    (laneValid),
		.laneResults  (laneResults),
		.issueIllegal (issueIllegal),
		.outValid     (outValid),
		.results      (results),
		.zeroMask     (zeroMask),
		.oflMask      (oflMask),
		.allZero      (allZero),
		.anyOfl       (anyOfl),
		.illegal      (illegal)
	);

endmodule

`default_nettype wire

// ==== logic/aluClusterPkg.sv ====
`default_nettype none

package aluClusterPkg;

	localparam int DATA_WIDTH = 16;

	// operation codes of the reference ALU
	typedef enum logic [3:0] {
		ADD  = 4'b0000,
		SUB  = 4'b0001,
		ROL  = 4'b0010,
		ROR  = 4'b0011,
		SLL  = 4'b0100,
		SRL  = 4'b0101,
		BTR  = 4'b0110,
		XOR  = 4'b0111,
		SEQ  = 4'b1000,
		SLT  = 4'b1001,
		SLE  = 4'b1010,
		SCO  = 4'b1011,
		SLBI = 4'b1100,
		ANDN = 4'b1101,
		LBI  = 4'b1110
	} aluOp;

	// the one code the reference leaves undefined
	localparam logic [3:0] OP_ILLEGAL = 4'b1111;

	// register format, both operands come from the host
	typedef struct packed {
		logic        isImm;
		aluOp        op;
		logic        signedOp;
		logic [9:0]  reserved;
	} rFormWord;

	// immediate format, imm replaces operand B on every lane
	typedef struct packed {
		logic        isImm;
		aluOp        op;
		logic [10:0] imm;
	} iFormWord;

	typedef union packed {
		rFormWord rForm;
		iFormWord iForm;
	} instrWord;

	typedef struct packed {
		aluOp op;
		logic invA;
		logic invB;
		logic cIn;
		logic signedOp;
	} aluCtrl;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] inA;
		logic [DATA_WIDTH-1:0] inB;
	} operandPair;

	typedef struct packed {
		logic [DATA_WIDTH-1:0] value;
		logic                  zero;
		logic                  ofl;
	} laneResult;

endpackage

`default_nettype wire

// ==== logic/aluLane.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluLane (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      issueValid,
	input  aluClusterPkg::aluCtrl     ctrl,
	input  aluClusterPkg::operandPair pair,
	output logic                      laneValid,
	output aluClusterPkg::laneResult  result
);

	logic [15:0] opA;
	logic [15:0] opB;
	logic [15:0] sum;
	logic [15:0] leftOut;
	logic [15:0] rightOut;
	logic [15:0] btrOut;
	logic        cOut;
	logic        sumZero;
	logic        sgnOvf;
	logic        arithOfl;
	logic        less;
	aluClusterPkg::laneResult resultNext;

	assign opA = ctrl.invA ? ~pair.inA : pair.inA;
	assign opB = ctrl.invB ? ~pair.inB : pair.inB;

	cla16 u_cla16 (
		.inA  (opA),
		.inB  (opB),
		.cIn  (ctrl.cIn),
		.sum  (sum),
		.cOut (cOut)
	);

	// one shifter per direction, low mode bit picks shift over rotate
	barrelShifter u_leftShifter (
		.value   (opA),
		.count   (opB[3:0]),
		.mode    ({1'b0, ctrl.op == aluClusterPkg::SLL}),
		.shifted (leftOut)
	);

	barrelShifter u_rightShifter (
		.value   (opA),
		.count   (opB[3:0]),
		.mode    ({1'b1, ctrl.op == aluClusterPkg::SRL}),
		.shifted (rightOut)
	);

	always_comb begin
		for (int b = 0; b < 16; b++) begin
			btrOut[b] = opA[15-b];
		end
	end

	assign sumZero = ~|sum;
	// same-sign inputs with a sum of the other sign
	assign sgnOvf = (opA[15] == opB[15]) & (sum[15] != opA[15]);
	assign arithOfl = ctrl.signedOp ? sgnOvf : cOut;
	// A minus B; unsigned less means a borrow, so no carry out
	assign less = ctrl.signedOp ? (sum[15] ^ sgnOvf) : ~cOut;

	always_comb begin
		resultNext.zero = sumZero;
		resultNext.ofl = 1'b0;
		case (ctrl.op)
			aluClusterPkg::ADD, aluClusterPkg::SUB: begin
				resultNext.value = sum;
				resultNext.ofl = arithOfl;
			end
			aluClusterPkg::ROL, aluClusterPkg::SLL: resultNext.value = leftOut;
			aluClusterPkg::ROR, aluClusterPkg::SRL: resultNext.value = rightOut;
			aluClusterPkg::BTR: resultNext.value = btrOut;
			aluClusterPkg::XOR: resultNext.value = opA ^ opB;
			aluClusterPkg::ANDN: resultNext.value = opA & ~opB;
			aluClusterPkg::SEQ: resultNext.value = {15'b0, sumZero};
			aluClusterPkg::SLT: begin
				resultNext.value = {15'b0, less};
				resultNext.ofl = arithOfl;
			end
			aluClusterPkg::SLE: begin
				resultNext.value = {15'b0, less | sumZero};
				resultNext.ofl = arithOfl;
			end
			aluClusterPkg::SCO: resultNext.value = {15'b0, cOut};
			aluClusterPkg::SLBI: resultNext.value = {opA[7:0], opB[7:0]};
			aluClusterPkg::LBI: resultNext.value = opB;
			default: resultNext.value = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			laneValid <= 1'b0;
		end else begin
			laneValid <= issueValid;
		end
	end

	always_ff @(posedge clk) begin
		if (issueValid) begin
			result <= resultNext;
		end
	end

endmodule

`default_nettype wire

// ==== logic/barrelShifter.sv ====
`timescale 1ns/1ns
`default_nettype none

module barrelShifter (
	input  logic [15:0] value,
	input  logic [3:0]  count,
	input  logic [1:0]  mode,
	output logic [15:0] shifted
);

	// mode 00 rotate left, 01 shift left, 10 rotate right, 11 logical shift right
	logic [15:0] stage [0:4];

	assign stage[0] = value;

	generate
		for (genvar s = 0; s < 4; s++) begin : gStage
			localparam int AMT = 1 << s;
			logic [15:0] moved;

			always_comb begin
				case (mode)
					2'b00: moved = {stage[s][15-AMT:0], stage[s][15:16-AMT]};
					2'b01: moved = {stage[s][15-AMT:0], {AMT{1'b0}}};
					2'b10: moved = {stage[s][AMT-1:0], stage[s][15:AMT]};
					default: moved = {{AMT{1'b0}}, stage[s][15:AMT]};
				endcase
			end

			// count bit s moves the word by 2**s
			assign stage[s+1] = count[s] ? moved : stage[s];
		end
	endgenerate

	assign shifted = stage[4];

endmodule

`default_nettype wire

// ==== logic/cla16.sv ====
`timescale 1ns/1ns
`default_nettype none

module cla16 (
	input  logic [15:0] inA,
	input  logic [15:0] inB,
	input  logic        cIn,
	output logic [15:0] sum,
	output logic        cOut
);

	logic [15:0] g;
	logic [15:0] p;
	logic [15:0] c;
	logic [3:0]  grpG;
	logic [3:0]  grpP;
	logic [4:0]  grpC;

	assign g = inA & inB;
	assign p = inA ^ inB;

	generate
		for (genvar grp = 0; grp < 4; grp++) begin : gGroup
			localparam int B = 4 * grp;

			// carries inside the group
			assign c[B]   = grpC[grp];
			assign c[B+1] = g[B] | (p[B] & grpC[grp]);
			assign c[B+2] = g[B+1] | (p[B+1] & g[B]) | (&p[B+1:B] & grpC[grp]);
			assign c[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (&p[B+2:B+1] & g[B])
				| (&p[B+2:B] & grpC[grp]);

			// group generate and propagate for the second level
			assign grpG[grp] = g[B+3] | (p[B+3] & g[B+2]) | (&p[B+3:B+2] & g[B+1])
				| (&p[B+3:B+1] & g[B]);
			assign grpP[grp] = &p[B+3:B];
		end
	endgenerate

	assign grpC[0] = cIn;
	assign grpC[1] = grpG[0] | (grpP[0] & cIn);
	assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (&grpP[1:0] & cIn);
	assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (&grpP[2:1] & grpG[0])
		| (&grpP[2:0] & cIn);
	assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (&grpP[3:2] & grpG[1])
		| (&grpP[3:1] & grpG[0]) | (&grpP[3:0] & cIn);

	assign sum = p ^ c;
	assign cOut = grpC[4];

endmodule

`default_nettype wire

// ==== logic/flagCollector.sv ====
`timescale 1ns/1ns
`default_nettype none

module flagCollector #(
	parameter int NUM_LANES = 4
) (
	input  logic                                               clk,
	input  logic                                               reset,
	input  logic [NUM_LANES-1:0]                               laneValid,
	input  aluClusterPkg::laneResult [NUM_LANES-1:0]           laneResults,
	input  logic                                               issueIllegal,
	output logic                                               outValid,
	output logic [NUM_LANES-1:0][aluClusterPkg::DATA_WIDTH-1:0] results,
	output logic [NUM_LANES-1:0]                               zeroMask,
	output logic [NUM_LANES-1:0]                               oflMask,
	output logic                                               allZero,
	output logic                                               anyOfl,
	output logic                                               illegal
);

	logic illegalDly;

	// matches the lane register stage
	always_ff @(posedge clk) begin
		if (reset) begin
			illegalDly <= 1'b0;
		end else begin
			illegalDly <= issueIllegal;
		end
	end

	// lanes move in lockstep, so this is lane 0's strobe
	assign outValid = &laneValid;

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			results[i] = laneResults[i].value;
			zeroMask[i] = laneResults[i].zero;
			oflMask[i] = laneResults[i].ofl;
		end
	end

	assign allZero = &zeroMask;
	assign anyOfl = |oflMask;
	assign illegal = outValid & illegalDly;

endmodule

`default_nettype wire

// ==== logic/issueDecoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module issueDecoder #(
	parameter int NUM_LANES = 4
) (
	input  logic                                        clk,
	input  logic                                        reset,
	input  logic                                        inValid,
	input  aluClusterPkg::instrWord                     instr,
	input  aluClusterPkg::operandPair [NUM_LANES-1:0]   operands,
	output logic                                        issueValid,
	output aluClusterPkg::aluCtrl                       ctrl,
	output aluClusterPkg::operandPair [NUM_LANES-1:0]   laneOperands,
	output logic                                        issueIllegal
);

	aluClusterPkg::aluOp                       opSel;
	aluClusterPkg::aluCtrl                     ctrlNext;
	aluClusterPkg::operandPair [NUM_LANES-1:0] operandsNext;
	logic [aluClusterPkg::DATA_WIDTH-1:0]      immExt;
	logic                                      isIllegal;

	assign immExt = {{(aluClusterPkg::DATA_WIDTH-11){instr.iForm.imm[10]}}, instr.iForm.imm};

	always_comb begin
		ctrlNext = '0;
		// isImm and op sit in the same bits for both views
		opSel = instr.rForm.op;
		if (instr.rForm.isImm) begin
			ctrlNext.signedOp = 1'b1;
		end else begin
			ctrlNext.signedOp = instr.rForm.signedOp;
		end
		isIllegal = (opSel == aluClusterPkg::OP_ILLEGAL);
		ctrlNext.op = opSel;
		case (opSel)
			// B minus A
			aluClusterPkg::SUB: begin
				ctrlNext.invA = 1'b1;
				ctrlNext.cIn = 1'b1;
			end
			// compares work on A minus B
			aluClusterPkg::SEQ, aluClusterPkg::SLT, aluClusterPkg::SLE: begin
				ctrlNext.invB = 1'b1;
				ctrlNext.cIn = 1'b1;
			end
			default: begin
			end
		endcase
		// illegal word turns into a load of zero
		if (isIllegal) begin
			ctrlNext.op = aluClusterPkg::LBI;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_LANES; i++) begin
			operandsNext[i] = operands[i];
			if (isIllegal) begin
				operandsNext[i].inB = '0;
			end else if (instr.iForm.isImm) begin
				operandsNext[i].inB = immExt;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			issueValid <= 1'b0;
			issueIllegal <= 1'b0;
		end else begin
			issueValid <= inValid;
			issueIllegal <= inValid & isIllegal;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			ctrl <= ctrlNext;
			laneOperands <= operandsNext;
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module aluClusterTb -f aluCluster.f
simOut=$(./obj_dir/ValuClusterTb 2>&1 || true)
printf '%s\n' "$simOut"
if printf '%s\n' "$simOut" | grep -qx "Simulation completed successfully"; then
	exit 0
else
	exit 1
fi
